//--- Makefile
# Verilator simulation of the Frogger color mapper

.PHONY: all lint clean

all:
	verilator --binary --timing -f frogger.f --top-module tbColorMapper
	@out="$$(./obj_dir/VtbColorMapper)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing -Wall -f frogger.f --top-module tbColorMapper

clean:
	rm -rf obj_dir

//--- bench/frogger_cases.txt
# O kind lane slot x y sets a slot (kind 0 car, 1 pad, indices from 0); N kind lane count
# F x y frog; C car pad collision bits; P x y red green blue probes a pixel
# background bands
P 300 100 0 200 255
P 100 50 0 200 0
P 690 50 255 255 255
P 10 10 255 255 255
P 300 240 0 200 0
P 100 318 255 204 0
P 101 318 69 69 69
P 620 400 255 204 0
P 150 320 69 69 69
P 300 450 0 200 0
# frog box edges
F 300 300
P 307 310 50 180 50
P 306 310 69 69 69
P 333 335 50 180 50
P 334 335 69 69 69
P 320 336 69 69 69
# frog over a lane 1 car
O 0 0 0 280 300
N 0 0 1
P 320 320 50 180 50
P 306 310 0 150 250
F 1000 1000
# slot beyond the lane count stays hidden
O 0 0 1 500 300
P 520 310 69 69 69
N 0 0 2
P 520 310 0 150 250
# lanes 2 to 4, overlap and wrap
O 0 1 0 100 340
O 0 1 1 300 320
N 0 1 2
O 0 2 0 100 380
O 0 2 1 2000 380
N 0 2 2
O 0 3 0 100 420
N 0 3 1
P 120 350 150 0 30
P 120 390 150 250 0
P 120 430 0 100 232
P 330 330 0 150 250
P 370 350 150 0 30
P 32 390 150 250 0
P 33 390 69 69 69
# pads and collision tints
O 1 0 0 200 100
N 1 0 1
P 240 120 34 139 34
P 241 120 0 200 255
C 1 0
P 300 100 255 0 0
P 220 120 34 139 34
C 0 2
P 300 100 179 255 187
C 0 0
# back-to-back pixels
P 290 320 0 150 250
P 300 100 0 200 255
P 120 350 150 0 30
P 50 320 255 204 0
P 0 390 150 250 0
P 690 50 255 255 255

//--- bench/tbColorMapper.sv
/* Color mapper testbench
   replays scenes and pixel probes from the cases file and checks the registered RGB */
`timescale 1ns/100ps
`include "frogger_defs.svh"

module tbColorMapper;
	import froggerPkg::*;

	logic                   Clk;
	logic                   reset;
	coordT                  DrawX;
	coordT                  DrawY;
	coordT                  FrogX;
	coordT                  FrogY;
	coordT                  CarLaneX [`LANE_COUNT][`LANE_SLOTS];
	coordT                  CarLaneY [`LANE_COUNT][`LANE_SLOTS];
	laneCountT              CarLaneCount [`LANE_COUNT];
	coordT                  PadLaneX [`LANE_COUNT][`LANE_SLOTS];
	coordT                  PadLaneY [`LANE_COUNT][`LANE_SLOTS];
	laneCountT              PadLaneCount [`LANE_COUNT];
	logic [`LANE_COUNT-1:0] CarCollision;
	logic [`LANE_COUNT-1:0] PadCollision;
	colorT                  Red;
	colorT                  Green;
	colorT                  Blue;

	int cycleCount = 0;
	int cycleLimit = 28;
	int checkCount = 0;
	int mismatchCount = 0;
	int otherErrors = 0;

	colorMapper i_dut
	(
		.Clk          (Clk),
		.reset        (reset),
		.DrawX        (DrawX),
		.DrawY        (DrawY),
		.FrogX        (FrogX),
		.FrogY        (FrogY),
		.CarLaneX     (CarLaneX),
		.CarLaneY     (CarLaneY),
		.CarLaneCount (CarLaneCount),
		.PadLaneX     (PadLaneX),
		.PadLaneY     (PadLaneY),
		.PadLaneCount (PadLaneCount),
		.CarCollision (CarCollision),
		.PadCollision (PadCollision),
		.Red          (Red),
		.Green        (Green),
		.Blue         (Blue)
	);

	// 20 ns clock
	always
	begin
		#10 Clk = ~Clk;
	end

	// run limit, sized from the cases file
	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout, the run did not finish within %0d cycles", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic checkColor(input colorT expRed, input colorT expGreen,
		input colorT expBlue, input coordT x, input coordT y);
		checkCount++;
		if (Red !== expRed || Green !== expGreen || Blue !== expBlue)
		begin
			mismatchCount++;
			$display("mismatch at %0t: pixel (%0d, %0d) gave %0d,%0d,%0d, expected %0d,%0d,%0d",
				$time, x, y, Red, Green, Blue, expRed, expGreen, expBlue);
		end
	endtask

	task automatic reportBadLine(input string text);
		otherErrors++;
		$display("cases file line could not be understood: %s", text);
	endtask

	// ----------------------------------------------------------
	// stimulus from the cases file
	// ----------------------------------------------------------
	initial
	begin : runCases
		int          fd;
		int          lineCount;
		int          lineLen;
		int          n;
		int          a;
		int          b;
		int          c;
		int          d;
		int          e;
		string       line;
		string       rest;
		logic [7:0]  op;
		logic        isPixel;
		colorT       expRed;
		colorT       expGreen;
		colorT       expBlue;

		Clk = 1'b0;
		reset = 1'b1;
		DrawX = '0;
		DrawY = '0;
		// frog parked off screen
		FrogX = coordT'(1000);
		FrogY = coordT'(1000);
		CarCollision = '0;
		PadCollision = '0;
		for (int lane = 0; lane < `LANE_COUNT; lane++)
		begin
			CarLaneCount[lane] = '0;
			PadLaneCount[lane] = '0;
			for (int slot = 0; slot < `LANE_SLOTS; slot++)
			begin
				CarLaneX[lane][slot] = '0;
				CarLaneY[lane][slot] = '0;
				PadLaneX[lane][slot] = '0;
				PadLaneY[lane][slot] = '0;
			end
		end

		// at most one cycle per line, plus reset and margin
		lineCount = 0;
		fd = $fopen("bench/frogger_cases.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				if ($fgets(line, fd) > 0)
					lineCount++;
			end
			$fclose(fd);
		end
		cycleLimit = 2 * lineCount + 8 + 20;

		repeat (8) @(posedge Clk);
		#2;
		checkColor('0, '0, '0, DrawX, DrawY);
		reset = 1'b0;

		fd = $fopen("bench/frogger_cases.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("cases file bench/frogger_cases.txt could not be opened");
		end
		else
		begin
			while (!$feof(fd))
			begin
				lineLen = $fgets(line, fd);
				if (lineLen < 2 || line[0] == "#")
					continue;
				op = line[0];
				rest = line.substr(1, line.len() - 1);
				isPixel = 1'b0;
				case (op)
					"O":
					begin
						n = $sscanf(rest, "%d %d %d %d %d", a, b, c, d, e);
						if (n != 5 || a > 1 || b >= `LANE_COUNT || c >= `LANE_SLOTS)
							reportBadLine(line);
						else if (a == 0)
						begin
							CarLaneX[b][c] = coordT'(d);
							CarLaneY[b][c] = coordT'(e);
						end
						else
						begin
							PadLaneX[b][c] = coordT'(d);
							PadLaneY[b][c] = coordT'(e);
						end
					end
					"N":
					begin
						n = $sscanf(rest, "%d %d %d", a, b, c);
						if (n != 3 || a > 1 || b >= `LANE_COUNT)
							reportBadLine(line);
						else if (a == 0)
							CarLaneCount[b] = laneCountT'(c);
						else
							PadLaneCount[b] = laneCountT'(c);
					end
					"F":
					begin
						n = $sscanf(rest, "%d %d", a, b);
						if (n != 2)
							reportBadLine(line);
						FrogX = coordT'(a);
						FrogY = coordT'(b);
					end
					"C":
					begin
						n = $sscanf(rest, "%d %d", a, b);
						if (n != 2)
							reportBadLine(line);
						CarCollision = a[`LANE_COUNT-1:0];
						PadCollision = b[`LANE_COUNT-1:0];
					end
					"P":
					begin
						n = $sscanf(rest, "%d %d %d %d %d", a, b, c, d, e);
						if (n != 5)
							reportBadLine(line);
						else
						begin
							DrawX = coordT'(a);
							DrawY = coordT'(b);
							expRed = colorT'(c);
							expGreen = colorT'(d);
							expBlue = colorT'(e);
							isPixel = 1'b1;
						end
					end
					default:
						reportBadLine(line);
				endcase
				// one pixel per clock, result one edge later
				@(posedge Clk);
				#2;
				if (isPixel)
					checkColor(expRed, expGreen, expBlue, DrawX, DrawY);
			end
			$fclose(fd);
		end

		$display("checks %0d, mismatches %0d, other errors %0d",
			checkCount, mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- design/backgroundPainter.sv
/* Background painter
   static scenery color for the current pixel */
`timescale 1ns/100ps
`include "frogger_defs.svh"

module backgroundPainter
(
	input  froggerPkg::coordT DrawX,
	input  froggerPkg::coordT DrawY,
	output froggerPkg::colorT Red,
	output froggerPkg::colorT Green,
	output froggerPkg::colorT Blue
);
	import froggerPkg::*;

	// road markings, three dashed lines 5 rows thick
	localparam int stripeRow1 = 318;
	localparam int stripeRow2 = 358;
	localparam int stripeRow3 = 398;
	localparam int stripeThick = 4;
	// dashes start every 200 columns, last one runs to the edge
	localparam int dashPitch = 200;
	localparam int dashLength = 100;
	localparam int lastDash = 600;

	logic inWater;
	logic inGrass;
	logic stripeRow;
	logic stripeCol;
	logic inPavement;

	// ----------------------------------------------------------
	// band decode
	// ----------------------------------------------------------
	assign inWater = DrawY >= `WATER_TOP && DrawY <= `WATER_BOTTOM;

	// top bank stops short of the wrap zone
	assign inGrass = (DrawY >= `GRASS_TOP && DrawY < `WATER_TOP && DrawX <= `GRASS_RIGHT) ||
		(DrawY >= `MEDIAN_TOP && DrawY <= `MEDIAN_BOTTOM) ||
		(DrawY >= `VERGE_TOP);

	assign stripeRow = (DrawY >= stripeRow1 && DrawY <= stripeRow1 + stripeThick) ||
		(DrawY >= stripeRow2 && DrawY <= stripeRow2 + stripeThick) ||
		(DrawY >= stripeRow3 && DrawY <= stripeRow3 + stripeThick);

	assign stripeCol = (DrawX <= dashLength) ||
		(DrawX >= dashPitch && DrawX <= dashPitch + dashLength) ||
		(DrawX >= 2 * dashPitch && DrawX <= 2 * dashPitch + dashLength) ||
		(DrawX >= lastDash);

	assign inPavement = DrawY >= `ROAD_TOP && DrawY <= `ROAD_BOTTOM;

	// ----------------------------------------------------------
	// first matching band wins
	// ----------------------------------------------------------
	always_comb
	begin
		if (inWater)
			{Red, Green, Blue} = `COLOR_WATER;
		else if (inGrass)
			{Red, Green, Blue} = `COLOR_GRASS;
		else if (stripeRow && stripeCol)
			{Red, Green, Blue} = `COLOR_STRIPE;
		else if (inPavement)
			{Red, Green, Blue} = `COLOR_PAVEMENT;
		else
			{Red, Green, Blue} = `COLOR_BLANK;
	end

endmodule

//--- design/colorMapper.sv
/* Frogger color mapper
   lane hit testers, scenery painter and registered priority stage */
`timescale 1ns/100ps
`include "frogger_defs.svh"

module colorMapper
(
	input  logic                     Clk,
	input  logic                     reset,
	input  froggerPkg::coordT        DrawX,
	input  froggerPkg::coordT        DrawY,
	input  froggerPkg::coordT        FrogX,
	input  froggerPkg::coordT        FrogY,
	input  froggerPkg::coordT        CarLaneX [`LANE_COUNT][`LANE_SLOTS],
	input  froggerPkg::coordT        CarLaneY [`LANE_COUNT][`LANE_SLOTS],
	input  froggerPkg::laneCountT    CarLaneCount [`LANE_COUNT],
	input  froggerPkg::coordT        PadLaneX [`LANE_COUNT][`LANE_SLOTS],
	input  froggerPkg::coordT        PadLaneY [`LANE_COUNT][`LANE_SLOTS],
	input  froggerPkg::laneCountT    PadLaneCount [`LANE_COUNT],
	input  logic [`LANE_COUNT-1:0]   CarCollision,
	input  logic [`LANE_COUNT-1:0]   PadCollision,
	output froggerPkg::colorT        Red,
	output froggerPkg::colorT        Green,
	output froggerPkg::colorT        Blue
);
	import froggerPkg::*;

	laneHitT carHit [`LANE_COUNT];
	laneHitT padHit [`LANE_COUNT];
	colorT   backRed;
	colorT   backGreen;
	colorT   backBlue;

	// ----------------------------------------------------------
	// per-lane hit tests
	// ----------------------------------------------------------
	genvar lane;
	generate
		for (lane = 0; lane < `LANE_COUNT; lane++)
		begin : laneTest
			laneHitTest
			#(
				.objectWidth (`CAR_WIDTH)
			)
			iCarTest
			(
				.DrawX     (DrawX),
				.DrawY     (DrawY),
				.LaneX     (CarLaneX[lane]),
				.LaneY     (CarLaneY[lane]),
				.LaneCount (CarLaneCount[lane]),
				.Hit       (carHit[lane])
			);

			laneHitTest
			#(
				.objectWidth (`PAD_WIDTH)
			)
			iPadTest
			(
				.DrawX     (DrawX),
				.DrawY     (DrawY),
				.LaneX     (PadLaneX[lane]),
				.LaneY     (PadLaneY[lane]),
				.LaneCount (PadLaneCount[lane]),
				.Hit       (padHit[lane])
			);
		end
	endgenerate

	// scenery behind all objects
	backgroundPainter iPainter
	(
		.DrawX (DrawX),
		.DrawY (DrawY),
		.Red   (backRed),
		.Green (backGreen),
		.Blue  (backBlue)
	);

	// ----------------------------------------------------------
	// selection and output register
	// ----------------------------------------------------------
	pixelPriority iPriority
	(
		.Clk          (Clk),
		.reset        (reset),
		.DrawX        (DrawX),
		.DrawY        (DrawY),
		.FrogX        (FrogX),
		.FrogY        (FrogY),
		.CarHit       (carHit),
		.PadHit       (padHit),
		.CarCollision (CarCollision),
		.PadCollision (PadCollision),
		.BackRed      (backRed),
		.BackGreen    (backGreen),
		.BackBlue     (backBlue),
		.Red          (Red),
		.Green        (Green),
		.Blue         (Blue)
	);

endmodule

//--- design/froggerPkg.sv
/* Frogger shared types
   coordinates, lane counts, per-slot hit flags and color components */
`include "frogger_defs.svh"

package froggerPkg;

	// screen coordinate or object position
	typedef logic [`COORD_WIDTH-1:0] coordT;

	// active objects in a lane, 0 up to LANE_SLOTS
	typedef logic [$clog2(`LANE_SLOTS + 1)-1:0] laneCountT;

	// one flag per object slot of a lane
	typedef logic [`LANE_SLOTS-1:0] laneHitT;

	// one 8-bit color component
	typedef logic [`COLOR_WIDTH-1:0] colorT;

endpackage

//--- design/frogger_defs.svh
/* Frogger color mapper constants
   screen geometry, object sizes, scene bands and fixed colors */
`ifndef FROGGER_DEFS_SVH
`define FROGGER_DEFS_SVH

// ----------------------------------------------------------
// widths and counts
// ----------------------------------------------------------
`define COORD_WIDTH        11
`define COLOR_WIDTH        8
`define LANE_SLOTS         4
`define LANE_COUNT         4

// object geometry
`define CAR_WIDTH          80
`define PAD_WIDTH          40
`define OBJECT_HEIGHT      40
// X at or past this has run off the right edge
`define WRAP_LIMIT         680

// frog box, drawn inset inside its square
`define FROG_SIZE          40
`define FROG_INSET_LEFT    7
`define FROG_INSET_RIGHT   7
`define FROG_INSET_TOP     10
`define FROG_INSET_BOTTOM  5

// ----------------------------------------------------------
// scene bands (rows and columns, inclusive)
// ----------------------------------------------------------
`define GRASS_TOP          40
`define GRASS_RIGHT        679
`define WATER_TOP          80
`define WATER_BOTTOM       239
`define MEDIAN_TOP         240
`define MEDIAN_BOTTOM      279
`define ROAD_TOP           280
`define ROAD_BOTTOM        439
`define VERGE_TOP          440

// ----------------------------------------------------------
// colors as {red, green, blue}
// ----------------------------------------------------------
`define COLOR_FROG         {8'd50, 8'd180, 8'd50}
`define COLOR_CAR1         {8'd0, 8'd150, 8'd250}
`define COLOR_CAR2         {8'd150, 8'd0, 8'd30}
`define COLOR_CAR3         {8'd150, 8'd250, 8'd0}
`define COLOR_CAR4         {8'd0, 8'd100, 8'd232}
`define COLOR_PAD          {8'd34, 8'd139, 8'd34}
`define COLOR_CARHIT       {8'd255, 8'd0, 8'd0}
`define COLOR_PADHIT       {8'd179, 8'd255, 8'd187}
`define COLOR_WATER        {8'd0, 8'd200, 8'd255}
`define COLOR_GRASS        {8'd0, 8'd200, 8'd0}
`define COLOR_STRIPE       {8'd255, 8'd204, 8'd0}
`define COLOR_PAVEMENT     {8'd69, 8'd69, 8'd69}
`define COLOR_BLANK        {8'd255, 8'd255, 8'd255}

`endif

//--- design/laneHitTest.sv
/* Lane hit test
   flags which object slots of one lane cover the current pixel */
`timescale 1ns/100ps
`include "frogger_defs.svh"

module laneHitTest
#(
	parameter int objectWidth = `CAR_WIDTH
)
(
	input  froggerPkg::coordT     DrawX,
	input  froggerPkg::coordT     DrawY,
	input  froggerPkg::coordT     LaneX [`LANE_SLOTS],
	input  froggerPkg::coordT     LaneY [`LANE_SLOTS],
	input  froggerPkg::laneCountT LaneCount,
	output froggerPkg::laneHitT   Hit
);
	import froggerPkg::*;

	always_comb
	begin : slotTest
		coordT leftEdge;
		coordT rightEdge;
		coordT bottomEdge;
		logic  slotActive;

		Hit = '0;
		for (int slot = 0; slot < `LANE_SLOTS; slot++)
		begin
			// edges wrap in 11 bits, same as the position counters
			rightEdge  = LaneX[slot] + coordT'(objectWidth);
			bottomEdge = LaneY[slot] + coordT'(`OBJECT_HEIGHT);
			slotActive = laneCountT'(slot) < LaneCount;

			// wrapped object reappears from the left border
			if (LaneX[slot] >= coordT'(`WRAP_LIMIT))
				leftEdge = '0;
			else
				leftEdge = LaneX[slot];

			Hit[slot] = slotActive &&
				DrawX >= leftEdge && DrawX <= rightEdge &&
				DrawY >= LaneY[slot] && DrawY <= bottomEdge;
		end
	end

endmodule

//--- design/pixelPriority.sv
/* Pixel priority stage
   picks frog, car, pad, collision tint or background and registers the RGB */
`timescale 1ns/100ps
`include "frogger_defs.svh"

module pixelPriority
(
	input  logic                    Clk,
	input  logic                    reset,
	input  froggerPkg::coordT       DrawX,
	input  froggerPkg::coordT       DrawY,
	input  froggerPkg::coordT       FrogX,
	input  froggerPkg::coordT       FrogY,
	input  froggerPkg::laneHitT     CarHit [`LANE_COUNT],
	input  froggerPkg::laneHitT     PadHit [`LANE_COUNT],
	input  logic [`LANE_COUNT-1:0]  CarCollision,
	input  logic [`LANE_COUNT-1:0]  PadCollision,
	input  froggerPkg::colorT       BackRed,
	input  froggerPkg::colorT       BackGreen,
	input  froggerPkg::colorT       BackBlue,
	output froggerPkg::colorT       Red,
	output froggerPkg::colorT       Green,
	output froggerPkg::colorT       Blue
);
	import froggerPkg::*;

	localparam int rgbWidth = 3 * $bits(colorT);

	// lane 1 first
	localparam logic [rgbWidth-1:0] carPalette [`LANE_COUNT] = '{
		`COLOR_CAR1,
		`COLOR_CAR2,
		`COLOR_CAR3,
		`COLOR_CAR4
	};

	coordT frogLeft;
	coordT frogRight;
	coordT frogTop;
	coordT frogBottom;
	logic  frogOn;

	logic                carFound;
	logic [rgbWidth-1:0] carColor;
	logic                padOn;
	logic [rgbWidth-1:0] nextColor;

	// ----------------------------------------------------------
	// frog box
	// ----------------------------------------------------------
	assign frogLeft   = FrogX + coordT'(`FROG_INSET_LEFT);
	assign frogRight  = FrogX + coordT'(`FROG_SIZE - `FROG_INSET_RIGHT);
	assign frogTop    = FrogY + coordT'(`FROG_INSET_TOP);
	assign frogBottom = FrogY + coordT'(`FROG_SIZE - `FROG_INSET_BOTTOM);

	assign frogOn = DrawX >= frogLeft && DrawX <= frogRight &&
		DrawY >= frogTop && DrawY <= frogBottom;

	// ----------------------------------------------------------
	// object selection
	// ----------------------------------------------------------

	// lowest car lane with any slot hit
	always_comb
	begin
		carFound = 1'b0;
		carColor = '0;
		for (int lane = 0; lane < `LANE_COUNT; lane++)
		begin
			if (!carFound && |CarHit[lane])
			begin
				carFound = 1'b1;
				carColor = carPalette[lane];
			end
		end
	end

	// pads all share one color
	always_comb
	begin
		padOn = 1'b0;
		for (int lane = 0; lane < `LANE_COUNT; lane++)
			padOn = padOn | (|PadHit[lane]);
	end

	always_comb
	begin
		if (frogOn)
			nextColor = `COLOR_FROG;
		else if (carFound)
			nextColor = carColor;
		else if (padOn)
			nextColor = `COLOR_PAD;
		// tints flood the whole free screen while a hit is flagged
		else if (|CarCollision)
			nextColor = `COLOR_CARHIT;
		else if (|PadCollision)
			nextColor = `COLOR_PADHIT;
		else
			nextColor = {BackRed, BackGreen, BackBlue};
	end

	// output register, one pixel per clock
	always_ff @(posedge Clk)
	begin
		if (reset)
			{Red, Green, Blue} <= '0;
		else
			{Red, Green, Blue} <= nextColor;
	end

endmodule

//--- frogger.f
+incdir+design
design/froggerPkg.sv
design/laneHitTest.sv
design/backgroundPainter.sv
design/pixelPriority.sv
design/colorMapper.sv
bench/tbColorMapper.sv
